/* project.f */
verilog/dram_bridge_pkg.sv
verilog/sync_fifo.sv
verilog/dram_rd_req_arbiter.sv
verilog/dram_rd_rx.sv
verilog/dram_rd_bridge.sv
tb/dram_model.sv
tb/dram_rd_bridge_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the DRAM read bridge testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module dram_rd_bridge_tb -o sim_dram_rd_bridge

status=0
./obj_dir/sim_dram_rd_bridge > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Verification failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

/* tb/dram_rd_bridge_tb.sv */
// Testbench for the DRAM read bridge with cache stimulus, checking assertions and summary.
`timescale 1ns/1ps

module dram_rd_bridge_tb;

  typedef logic [dram_bridge_pkg::ADDR_W-1:0]    addr_t;
  typedef logic [dram_bridge_pkg::DATA_W-1:0]    word_t;
  typedef logic [dram_bridge_pkg::NUM_CACHE-1:0] mask_t;
  typedef enum logic [1:0] {PH_GAP, PH_REQ, PH_DATA, PH_DONE} phase_e;

  localparam int NC          = dram_bridge_pkg::NUM_CACHE;
  localparam int BLOCK_BYTES = dram_bridge_pkg::BLOCK_WORDS * dram_bridge_pkg::BYTES_PER_WORD;
  localparam int BURST_BYTES = dram_bridge_pkg::BURST_LEN * dram_bridge_pkg::BYTES_PER_WORD;
  localparam int REQS_PER_CACHE = 4;
  localparam int WAIT_LIMIT     = 2000;
  localparam int RUN_LIMIT      = 40000;

  logic                       clk_i;
  logic                       arst_n_i;
  mask_t                      rd_v_i;
  logic [NC-1:0][dram_bridge_pkg::ADDR_W-1:0] rd_addr_i;
  mask_t                      rd_ready_o;
  word_t                      dma_data_o;
  mask_t                      dma_data_v_o;
  mask_t                      dma_data_ready_i;
  logic                       app_en_o;
  addr_t                      app_addr_o;
  logic                       app_rdy_i;
  logic                       app_rd_data_valid_i;
  word_t                      app_rd_data_i;
  logic                       app_rd_data_end_i;

  // expected words per cache and a registered copy of each queue head.
  word_t                      exp_q [NC][$];
  logic [NC-1:0][dram_bridge_pkg::DATA_W-1:0] exp_head;
  mask_t                      exp_busy;

  phase_e                     phase [NC];
  int unsigned                gap [NC];
  int unsigned                wait_cnt [NC];
  int unsigned                reqs_left [NC];
  mask_t                      done;
  int                         check_err = 0;
  int                         timeout_err = 0;

  int                         cmd_idx_q;
  addr_t                      cmd_base_q;
  addr_t                      cur_base;
  logic                       cmd_fire;
  logic                       cmd_ok;

  dram_rd_bridge i_dut (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .rd_v_i              (rd_v_i),
    .rd_addr_i           (rd_addr_i),
    .rd_ready_o          (rd_ready_o),
    .dma_data_o          (dma_data_o),
    .dma_data_v_o        (dma_data_v_o),
    .dma_data_ready_i    (dma_data_ready_i),
    .app_en_o            (app_en_o),
    .app_addr_o          (app_addr_o),
    .app_rdy_i           (app_rdy_i),
    .app_rd_data_valid_i (app_rd_data_valid_i),
    .app_rd_data_i       (app_rd_data_i),
    .app_rd_data_end_i   (app_rd_data_end_i)
  );

  dram_model i_dram (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .app_en_i            (app_en_o),
    .app_addr_i          (app_addr_o),
    .app_rdy_o           (app_rdy_i),
    .app_rd_data_valid_o (app_rd_data_valid_i),
    .app_rd_data_o       (app_rd_data_i),
    .app_rd_data_end_o   (app_rd_data_end_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic flag_mismatch(input string msg);
    check_err++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  // pop the words that the caches take in this cycle.
  task automatic take_words();
    for (int c = 0; c < NC; c++) begin
      if (dma_data_v_o[c] && dma_data_ready_i[c] && exp_q[c].size() != 0) begin
        void'(exp_q[c].pop_front());
      end
    end
  endtask

  task automatic refresh_heads();
    for (int c = 0; c < NC; c++) begin
      exp_busy[c] <= (exp_q[c].size() != 0);
      exp_head[c] <= (exp_q[c].size() != 0) ? exp_q[c][0] : '0;
    end
  endtask

  // one step of a blocking cache that idles, requests a block and then waits for its words.
  task automatic step_cache(input int c);
    addr_t addr;
    case (phase[c])
      PH_GAP: begin
        if (gap[c] != 0) begin
          gap[c]--;
        end else begin
          addr = addr_t'($urandom) & ~addr_t'(BLOCK_BYTES - 1);
          rd_v_i[c]    <= 1'b1;
          rd_addr_i[c] <= addr;
          for (int w = 0; w < dram_bridge_pkg::BLOCK_WORDS; w++) begin
            exp_q[c].push_back(word_t'(addr + addr_t'(w * dram_bridge_pkg::BYTES_PER_WORD)));
          end
          wait_cnt[c] = 0;
          phase[c] = PH_REQ;
        end
      end
      PH_REQ: begin
        if (rd_v_i[c] && rd_ready_o[c]) begin
          rd_v_i[c] <= 1'b0;
          wait_cnt[c] = 0;
          phase[c] = PH_DATA;
        end else if (wait_cnt[c] == WAIT_LIMIT) begin
          $display("timeout: the request of cache %0d was never accepted", c);
          timeout_err++;
          rd_v_i[c] <= 1'b0;
          phase[c] = PH_DONE;
          done[c] = 1'b1;
        end else begin
          wait_cnt[c]++;
        end
      end
      PH_DATA: begin
        if (exp_q[c].size() == 0) begin
          reqs_left[c]--;
          if (reqs_left[c] == 0) begin
            phase[c] = PH_DONE;
            done[c] = 1'b1;
          end else begin
            gap[c] = $urandom_range(6);
            phase[c] = PH_GAP;
          end
        end else if (wait_cnt[c] == WAIT_LIMIT) begin
          $display("timeout: cache %0d did not receive its whole block", c);
          timeout_err++;
          phase[c] = PH_DONE;
          done[c] = 1'b1;
        end else begin
          wait_cnt[c]++;
        end
      end
      default: begin
      end
    endcase
  endtask

  initial begin
    int cycle;
    void'($urandom(59501));
    arst_n_i         = 1'b0;
    rd_v_i           = '0;
    rd_addr_i        = '0;
    dma_data_ready_i = '0;
    exp_busy         = '0;
    exp_head         = '0;
    done             = '0;
    for (int c = 0; c < NC; c++) begin
      phase[c]     = PH_GAP;
      gap[c]       = c;
      wait_cnt[c]  = 0;
      reqs_left[c] = REQS_PER_CACHE;
    end
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    cycle = 0;
    while (done != '1 && cycle < RUN_LIMIT) begin
      @(posedge clk_i);
      cycle++;
      take_words();
      for (int c = 0; c < NC; c++) begin
        step_cache(c);
      end
      dma_data_ready_i <= mask_t'($urandom);
      refresh_heads();
    end
    if (done != '1) begin
      $display("timeout: the caches did not finish within %0d cycles", RUN_LIMIT);
      timeout_err++;
    end
    repeat (4) @(posedge clk_i);
    $display("errors: %0d check failures, %0d timeouts", check_err, timeout_err);
    if (check_err == 0 && timeout_err == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // the first burst of a block starts at a pending request address and the later ones follow it.
  assign cmd_fire = app_en_o & app_rdy_i;

  always_comb begin
    cur_base = (cmd_idx_q == 0) ? app_addr_o : cmd_base_q;
    cmd_ok   = 1'b0;
    for (int c = 0; c < NC; c++) begin
      if (rd_v_i[c] && rd_addr_i[c] == cur_base) begin
        cmd_ok = 1'b1;
      end
    end
    if (app_addr_o != cur_base + addr_t'(cmd_idx_q * BURST_BYTES)) begin
      cmd_ok = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cmd_idx_q  <= 0;
      cmd_base_q <= '0;
    end else if (cmd_fire) begin
      if (cmd_idx_q == 0) begin
        cmd_base_q <= app_addr_o;
      end
      cmd_idx_q <= (cmd_idx_q == dram_bridge_pkg::BURSTS_PER_BLOCK - 1) ? 0 : cmd_idx_q + 1;
    end
  end

  a_reset_idle: assert property (@(posedge clk_i)
    (!arst_n_i || !$past(arst_n_i)) |-> (!app_en_o && rd_ready_o == '0 && dma_data_v_o == '0)
  ) else flag_mismatch("outputs not idle around reset");

  a_cmd_addr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_fire |-> cmd_ok
  ) else flag_mismatch($sformatf("unexpected command address 0x%07h", app_addr_o));

  a_ready_last: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (rd_ready_o != '0) |-> (cmd_fire && $onehot(rd_ready_o) &&
                            cmd_idx_q == dram_bridge_pkg::BURSTS_PER_BLOCK - 1)
  ) else flag_mismatch("rd_ready_o outside the last burst command");

  a_one_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(dma_data_v_o)
  ) else flag_mismatch("more than one dma_data_v_o bit high");

  for (genvar gc = 0; gc < NC; gc++) begin : g_cache_chk
    a_data_value: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (dma_data_v_o[gc] && dma_data_ready_i[gc]) |-> (exp_busy[gc] && dma_data_o == exp_head[gc])
    ) else flag_mismatch($sformatf("cache %0d took wrong word 0x%08h", gc, dma_data_o));

    a_valid_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      dma_data_v_o[gc] |-> exp_busy[gc]
    ) else flag_mismatch($sformatf("data valid for idle cache %0d", gc));

    a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (dma_data_v_o[gc] && !dma_data_ready_i[gc]) |=> (dma_data_v_o[gc] && $stable(dma_data_o))
    ) else flag_mismatch($sformatf("stalled word to cache %0d changed", gc));
  end

endmodule

/* tb/dram_model.sv */
// Behavioral DRAM read port with a command queue, random ready stalls and burst data returns.
`timescale 1ns/1ps

module dram_model (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic                               app_en_i,
  input  logic [dram_bridge_pkg::ADDR_W-1:0] app_addr_i,
  output logic                               app_rdy_o,
  output logic                               app_rd_data_valid_o,
  output logic [dram_bridge_pkg::DATA_W-1:0] app_rd_data_o,
  output logic                               app_rd_data_end_o
);

  typedef logic [dram_bridge_pkg::ADDR_W-1:0] addr_t;
  typedef logic [dram_bridge_pkg::DATA_W-1:0] word_t;

  // accepted burst start addresses, answered strictly in order.
  addr_t cmd_q [$];
  addr_t beat_addr;
  int    beat;

  initial begin
    app_rdy_o           = 1'b0;
    app_rd_data_valid_o = 1'b0;
    app_rd_data_o       = '0;
    app_rd_data_end_o   = 1'b0;
    beat                = 0;
    forever begin
      @(posedge clk_i or negedge arst_n_i);
      if (!arst_n_i) begin
        cmd_q.delete();
        beat = 0;
        app_rdy_o           <= 1'b0;
        app_rd_data_valid_o <= 1'b0;
        app_rd_data_o       <= '0;
        app_rd_data_end_o   <= 1'b0;
      end else begin
        if (app_en_i && app_rdy_o) begin
          cmd_q.push_back(app_addr_i);
        end
        // roughly one cycle in four the controller refuses a command.
        app_rdy_o           <= ($urandom_range(3) != 0);
        app_rd_data_valid_o <= 1'b0;
        app_rd_data_end_o   <= 1'b0;
        // a beat goes out in about two cycles of three, so bursts arrive with gaps.
        if (cmd_q.size() != 0 && $urandom_range(2) != 0) begin
          beat_addr = cmd_q[0] + addr_t'(beat * dram_bridge_pkg::BYTES_PER_WORD);
          app_rd_data_valid_o <= 1'b1;
          app_rd_data_o       <= word_t'(beat_addr);
          app_rd_data_end_o   <= (beat == dram_bridge_pkg::BURST_LEN - 1);
          if (beat == dram_bridge_pkg::BURST_LEN - 1) begin
            beat = 0;
            void'(cmd_q.pop_front());
          end else begin
            beat++;
          end
        end
      end
    end
  end

endmodule

/* verilog/dram_rd_bridge.sv */
// Top level of the DRAM read bridge joining the request arbiter and the receive block.
`timescale 1ns/1ps

module dram_rd_bridge (
  input  logic                                                         clk_i,
  input  logic                                                         arst_n_i,

  // cache block requests.
  input  logic [dram_bridge_pkg::NUM_CACHE-1:0]                        rd_v_i,
  input  logic [dram_bridge_pkg::NUM_CACHE-1:0][dram_bridge_pkg::ADDR_W-1:0] rd_addr_i,
  output logic [dram_bridge_pkg::NUM_CACHE-1:0]                        rd_ready_o,

  // fill data back to the caches.
  output logic [dram_bridge_pkg::DATA_W-1:0]                           dma_data_o,
  output logic [dram_bridge_pkg::NUM_CACHE-1:0]                        dma_data_v_o,
  input  logic [dram_bridge_pkg::NUM_CACHE-1:0]                        dma_data_ready_i,

  // DRAM controller application port.
  output logic                                                         app_en_o,
  output logic [dram_bridge_pkg::ADDR_W-1:0]                           app_addr_o,
  input  logic                                                         app_rdy_i,
  input  logic                                                         app_rd_data_valid_i,
  input  logic [dram_bridge_pkg::DATA_W-1:0]                           app_rd_data_i,
  input  logic                                                         app_rd_data_end_i
);

  logic                                    tag_v;
  logic [dram_bridge_pkg::CACHE_IDX_W-1:0] tag;
  logic                                    tag_ready;

  dram_rd_req_arbiter i_arb (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .rd_v_i      (rd_v_i),
    .rd_addr_i   (rd_addr_i),
    .rd_ready_o  (rd_ready_o),
    .app_en_o    (app_en_o),
    .app_addr_o  (app_addr_o),
    .app_rdy_i   (app_rdy_i),
    .tag_v_o     (tag_v),
    .tag_o       (tag),
    .tag_ready_i (tag_ready)
  );

  dram_rd_rx i_rx (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .tag_v_i             (tag_v),
    .tag_i               (tag),
    .tag_ready_o         (tag_ready),
    .app_rd_data_valid_i (app_rd_data_valid_i),
    .app_rd_data_i       (app_rd_data_i),
    .app_rd_data_end_i   (app_rd_data_end_i),
    .dma_data_o          (dma_data_o),
    .dma_data_v_o        (dma_data_v_o),
    .dma_data_ready_i    (dma_data_ready_i)
  );

endmodule

/* verilog/dram_rd_rx.sv */
// Receive block that buffers DRAM read beats and steers them to the tagged cache.
`timescale 1ns/1ps

module dram_rd_rx (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,

  input  logic                                    tag_v_i,
  input  logic [dram_bridge_pkg::CACHE_IDX_W-1:0] tag_i,
  output logic                                    tag_ready_o,

  input  logic                                    app_rd_data_valid_i,
  input  logic [dram_bridge_pkg::DATA_W-1:0]      app_rd_data_i,
  // the burst boundary is found by counting beats, so this flag is not looked at.
  input  logic                                    app_rd_data_end_i,

  output logic [dram_bridge_pkg::DATA_W-1:0]      dma_data_o,
  output logic [dram_bridge_pkg::NUM_CACHE-1:0]   dma_data_v_o,
  input  logic [dram_bridge_pkg::NUM_CACHE-1:0]   dma_data_ready_i
);

  logic                                    data_ready;
  logic                                    data_v;
  logic [dram_bridge_pkg::DATA_W-1:0]      data_head;
  logic                                    data_yumi;

  logic                                    tag_v;
  logic [dram_bridge_pkg::CACHE_IDX_W-1:0] tag_head;
  logic                                    tag_yumi;

  logic [dram_bridge_pkg::BEAT_CNT_W-1:0]  beat_cnt_q;
  logic                                    last_beat;

  // the DRAM return stream cannot be stalled, so this buffer absorbs it.
  sync_fifo #(
    .width_p (dram_bridge_pkg::DATA_W),
    .depth_p (dram_bridge_pkg::DATA_FIFO_DEPTH)
  ) i_data_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (app_rd_data_valid_i),
    .data_i   (app_rd_data_i),
    .ready_o  (data_ready),
    .v_o      (data_v),
    .data_o   (data_head),
    .yumi_i   (data_yumi)
  );

  // one tag per outstanding burst, in command order.
  sync_fifo #(
    .width_p (dram_bridge_pkg::CACHE_IDX_W),
    .depth_p (dram_bridge_pkg::NUM_CACHE)
  ) i_tag_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (tag_v_i),
    .data_i   (tag_i),
    .ready_o  (tag_ready_o),
    .v_o      (tag_v),
    .data_o   (tag_head),
    .yumi_i   (tag_yumi)
  );

  // all caches see the same word and only the tagged one sees valid.
  assign dma_data_o   = data_head;
  assign dma_data_v_o = (data_v & tag_v)
                      ? ({{(dram_bridge_pkg::NUM_CACHE-1){1'b0}}, 1'b1} << tag_head)
                      : '0;

  assign data_yumi = data_v & tag_v & dma_data_ready_i[tag_head];
  assign last_beat = (beat_cnt_q == dram_bridge_pkg::LAST_BEAT);
  // the tag leaves with the final beat of its burst.
  assign tag_yumi  = data_yumi & last_beat;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beat_cnt_q <= '0;
    end else if (data_yumi) begin
      beat_cnt_q <= last_beat ? '0 : beat_cnt_q + 1'b1;
    end
  end

  // the tag FIFO depth limits the bursts in flight, which must fit the data buffer.
  a_data_no_overflow: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) app_rd_data_valid_i |-> data_ready
  ) else $error("dram_rd_rx: DRAM beat arrived with the data FIFO full");

endmodule

/* verilog/dram_rd_req_arbiter.sv */
// Round-robin arbiter that turns cache block requests into DRAM burst commands and tags.
`timescale 1ns/1ps

module dram_rd_req_arbiter (
  input  logic                                                         clk_i,
  input  logic                                                         arst_n_i,

  input  logic [dram_bridge_pkg::NUM_CACHE-1:0]                        rd_v_i,
  input  logic [dram_bridge_pkg::NUM_CACHE-1:0][dram_bridge_pkg::ADDR_W-1:0] rd_addr_i,
  output logic [dram_bridge_pkg::NUM_CACHE-1:0]                        rd_ready_o,

  output logic                                                         app_en_o,
  output logic [dram_bridge_pkg::ADDR_W-1:0]                           app_addr_o,
  input  logic                                                         app_rdy_i,

  output logic                                                         tag_v_o,
  output logic [dram_bridge_pkg::CACHE_IDX_W-1:0]                      tag_o,
  input  logic                                                         tag_ready_i
);

  logic                                     busy_q;
  logic [dram_bridge_pkg::CACHE_IDX_W-1:0]  sel_q;
  logic [dram_bridge_pkg::CACHE_IDX_W-1:0]  last_q;
  logic [dram_bridge_pkg::BURST_IDX_W-1:0]  burst_q;

  logic                                     pick_v;
  logic [dram_bridge_pkg::CACHE_IDX_W-1:0]  pick_idx;
  logic                                     issue;
  logic                                     block_done;
  logic [dram_bridge_pkg::ADDR_W-1:0]       burst_ext;

  // search the caches starting just after the last grant.
  // the loop runs from the farthest candidate to the nearest, so the nearest wins.
  always_comb begin
    int cand;
    pick_v   = 1'b0;
    pick_idx = last_q;
    for (int i = dram_bridge_pkg::NUM_CACHE; i >= 1; i--) begin
      cand = (int'(last_q) + i) % dram_bridge_pkg::NUM_CACHE;
      if (rd_v_i[cand]) begin
        pick_v   = 1'b1;
        pick_idx = cand[dram_bridge_pkg::CACHE_IDX_W-1:0];
      end
    end
  end

  // a command only goes out when the tag can be recorded in the same cycle.
  assign app_en_o   = busy_q & tag_ready_i;
  assign issue      = busy_q & tag_ready_i & app_rdy_i;
  assign tag_v_o    = issue;
  assign tag_o      = sel_q;
  assign block_done = issue & (burst_q == dram_bridge_pkg::LAST_BURST);

  // the cache keeps its address stable until rd_ready_o, so it is used directly.
  always_comb begin
    burst_ext = '0;
    burst_ext[dram_bridge_pkg::BURST_IDX_W-1:0] = burst_q;
    app_addr_o = rd_addr_i[sel_q] + burst_ext * dram_bridge_pkg::BURST_BYTES;
  end

  // the request is acknowledged together with its final burst command.
  assign rd_ready_o = block_done
                    ? ({{(dram_bridge_pkg::NUM_CACHE-1){1'b0}}, 1'b1} << sel_q)
                    : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q  <= 1'b0;
      sel_q   <= '0;
      burst_q <= '0;
      // start from the top index so cache 0 is served first.
      last_q  <= '1;
    end else if (!busy_q) begin
      if (pick_v) begin
        busy_q  <= 1'b1;
        sel_q   <= pick_idx;
        burst_q <= '0;
      end
    end else if (issue) begin
      if (block_done) begin
        busy_q <= 1'b0;
        last_q <= sel_q;
      end else begin
        burst_q <= burst_q + 1'b1;
      end
    end
  end

  // the DRAM port expects a command to be held until it is taken.
  a_app_en_held: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) (app_en_o && !app_rdy_i) |=> app_en_o
  ) else $error("dram_rd_req_arbiter: app_en_o dropped before app_rdy_i");

endmodule

/* verilog/sync_fifo.sv */
// First-word-fall-through FIFO with valid/ready input and valid/yumi output.
`timescale 1ns/1ps

module sync_fifo #(
  parameter int width_p = 8,
  parameter int depth_p = 4
) (
  input  logic               clk_i,
  input  logic               arst_n_i,

  input  logic               v_i,
  input  logic [width_p-1:0] data_i,
  output logic               ready_o,

  output logic               v_o,
  output logic [width_p-1:0] data_o,
  input  logic               yumi_i
);

  localparam int PTR_W = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int CNT_W = $clog2(depth_p + 1);

  logic [width_p-1:0] mem_q [depth_p];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               push;
  logic               pop;

  assign ready_o = (count_q != CNT_W'(depth_p));
  assign v_o     = (count_q != '0);
  assign push    = v_i & ready_o;
  assign pop     = yumi_i & v_o;

  // the head is read straight from the array, so a word is visible the cycle after it lands.
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(depth_p - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(depth_p - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // the consumer may only take a head that is actually there.
  a_no_yumi_when_empty: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) yumi_i |-> v_o
  ) else $error("sync_fifo: yumi_i while empty");

  // a write into a full buffer would be lost.
  a_no_write_when_full: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) v_i |-> ready_o
  ) else $error("sync_fifo: write while full");

endmodule

/* verilog/dram_bridge_pkg.sv */
// Package with the sizing constants and derived widths of the DRAM read bridge.
package dram_bridge_pkg;

  // number of blocking caches that share the DRAM read port.
  localparam int NUM_CACHE = 4;
  localparam int CACHE_IDX_W = (NUM_CACHE > 1) ? $clog2(NUM_CACHE) : 1;

  // DRAM word and byte address widths.
  localparam int DATA_W = 32;
  localparam int ADDR_W = 28;
  localparam int BYTES_PER_WORD = DATA_W / 8;

  // a cache block is filled by one or more DRAM bursts.
  localparam int BLOCK_WORDS = 8;
  localparam int BURST_LEN = 4;
  localparam int BURSTS_PER_BLOCK = BLOCK_WORDS / BURST_LEN;

  localparam int BEAT_CNT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
  localparam int BURST_IDX_W = (BURSTS_PER_BLOCK > 1) ? $clog2(BURSTS_PER_BLOCK) : 1;

  // index of the final beat in a burst and of the final burst in a block.
  localparam logic [BEAT_CNT_W-1:0] LAST_BEAT = BEAT_CNT_W'(BURST_LEN - 1);
  localparam logic [BURST_IDX_W-1:0] LAST_BURST = BURST_IDX_W'(BURSTS_PER_BLOCK - 1);

  // byte distance between two bursts of the same block.
  localparam logic [ADDR_W-1:0] BURST_BYTES = ADDR_W'(BURST_LEN * BYTES_PER_WORD);

  // the tag FIFO has one entry per cache and each entry stands for one burst in flight,
  // so the data buffer must hold that many whole bursts.
  localparam int DATA_FIFO_DEPTH = NUM_CACHE * BURST_LEN;

endpackage
